// ==== verilog/hv_pkg.sv ====
package hv_pkg;

    // ----------------------------------------------------------------------
    // hypervector geometry
    // ----------------------------------------------------------------------

    // bits per hypervector
    localparam int hv_dim = 1024;

    // rotation amount width, one stage per bit
    localparam int shift_w = $clog2(hv_dim);

    // ----------------------------------------------------------------------
    // types
    // ----------------------------------------------------------------------

    // one dense binary hypervector
    typedef logic [hv_dim-1:0] hv_t;

endpackage

// ==== verilog/enc_pkg.sv ====
package enc_pkg;

    import hv_pkg::*;

    // ----------------------------------------------------------------------
    // item memory and bundle limits
    // ----------------------------------------------------------------------

    // key slots in the item memory
    localparam int slot_count = 16;
    localparam int slot_w = $clog2(slot_count);

    // per-bit ones counter width
    localparam int count_w = 8;

    // counters stop here, so this is the longest exact record
    localparam int max_bundle = (1 << count_w) - 1;

    // ----------------------------------------------------------------------
    // strobed payloads
    // ----------------------------------------------------------------------

    // one record item: key slot, rotation and value
    typedef struct packed {
        logic [slot_w-1:0]  slot;
        logic [shift_w-1:0] shift;
        hv_t                value;
        logic               last;
    } enc_cmd_t;

    // item memory write
    typedef struct packed {
        logic [slot_w-1:0] slot;
        hv_t               key;
    } mem_wr_t;

    // bundled record, majority plus item count
    typedef struct packed {
        hv_t                hv;
        logic [count_w-1:0] count;
    } enc_result_t;

endpackage

// ==== verilog/hv_permute.sv ====
`timescale 1ns/100ps

module hv_permute
    import hv_pkg::*;
(
    input  logic               clk,
    input  logic               reset,

    // incoming item
    input  logic               in_valid,
    input  hv_t                in_hv,
    input  logic [shift_w-1:0] in_shift,
    input  logic               in_last,

    // rotated item, one cycle later
    output logic               out_valid,
    output hv_t                out_hv,
    output logic               out_last
);

    // ----------------------------------------------------------------------
    // log2 rotator
    // ----------------------------------------------------------------------

    // stage[0] is the input, stage[shift_w] is fully rotated
    hv_t stage [shift_w+1];

    assign stage[0] = in_hv;

    // stage k rotates right by 2**k when shift bit k is set
    for (genvar k = 0; k < shift_w; k++) begin : g_stage
        localparam int amt = 1 << k;

        hv_t rotated;

        // low bits wrap round to the top
        assign rotated = {stage[k][amt-1:0], stage[k][hv_dim-1:amt]};

        // pass through when this bit is clear
        assign stage[k+1] = in_shift[k] ? rotated : stage[k];
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------

    // strobe and last flag
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // last only means something with valid
            out_last  <= in_valid & in_last;
        end
    end

    // data only moves on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_hv <= stage[shift_w];
        end
    end

endmodule

// ==== verilog/item_memory.sv ====
`timescale 1ns/100ps

module item_memory
    import hv_pkg::*;
    import enc_pkg::*;
(
    input  logic              clk,

    // write port, lands on the next edge
    input  logic              wr_valid,
    input  mem_wr_t           wr,

    // read port, registered
    input  logic              rd_valid,
    input  logic [slot_w-1:0] rd_slot,
    output hv_t               rd_hv
);

    // ----------------------------------------------------------------------
    // key store
    // ----------------------------------------------------------------------

    // one key hypervector per slot
    hv_t mem [slot_count];

    // ----------------------------------------------------------------------
    // read and write
    // ----------------------------------------------------------------------

    // read samples the array before this edge's write lands,
    // so a same-slot write in the same cycle returns old data
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rd_hv <= mem[rd_slot];
        end
    end

    // key update
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr.slot] <= wr.key;
        end
    end

endmodule

// ==== verilog/hv_bundler.sv ====
`timescale 1ns/100ps

module hv_bundler
    import hv_pkg::*;
    import enc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // aligned streams from permuter and item memory
    input  logic        in_valid,
    input  hv_t         rot_hv,
    input  hv_t         key_hv,
    input  logic        in_last,

    // one strobe per record
    output logic        res_valid,
    output enc_result_t res
);

    // ----------------------------------------------------------------------
    // state
    // ----------------------------------------------------------------------

    // ones count per bit position
    logic [count_w-1:0] bit_cnt      [hv_dim];
    logic [count_w-1:0] bit_cnt_next [hv_dim];

    // items so far in this record
    logic [count_w-1:0] item_cnt;
    logic [count_w-1:0] item_cnt_next;

    // bound item and majority over the record
    hv_t                bound;
    hv_t                majority;

    // ----------------------------------------------------------------------
    // bind, count, vote
    // ----------------------------------------------------------------------

    always_comb begin
        // binding is a plain XOR
        bound = rot_hv ^ key_hv;

        // item count includes the current item, saturating
        if (item_cnt == count_w'(max_bundle)) begin
            item_cnt_next = item_cnt;
        end else begin
            item_cnt_next = item_cnt + 1'b1;
        end

        for (int i = 0; i < hv_dim; i++) begin
            // per-bit saturating add
            if (bound[i] && (bit_cnt[i] != count_w'(max_bundle))) begin
                bit_cnt_next[i] = bit_cnt[i] + 1'b1;
            end else begin
                bit_cnt_next[i] = bit_cnt[i];
            end

            // strict majority, a tie gives 0
            majority[i] = {bit_cnt_next[i], 1'b0} > {1'b0, item_cnt_next};
        end
    end

    // ----------------------------------------------------------------------
    // counters and result strobe
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            item_cnt  <= '0;
            for (int i = 0; i < hv_dim; i++) begin
                bit_cnt[i] <= '0;
            end
        end else begin
            res_valid <= in_valid & in_last;
            if (in_valid) begin
                if (in_last) begin
                    // record closed, next item starts fresh
                    item_cnt <= '0;
                    for (int i = 0; i < hv_dim; i++) begin
                        bit_cnt[i] <= '0;
                    end
                end else begin
                    item_cnt <= item_cnt_next;
                    bit_cnt  <= bit_cnt_next;
                end
            end
        end
    end

    // result payload, loaded with the closing item
    always_ff @(posedge clk) begin
        if (in_valid && in_last) begin
            res.hv    <= majority;
            res.count <= item_cnt_next;
        end
    end

endmodule

// ==== verilog/hv_encoder.sv ====
`timescale 1ns/100ps

module hv_encoder
    import hv_pkg::*;
    import enc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    // record items
    input  logic        cmd_valid,
    input  enc_cmd_t    cmd,

    // item memory load
    input  logic        wr_valid,
    input  mem_wr_t     wr,

    // bundled records
    output logic        res_valid,
    output enc_result_t res
);

    // ----------------------------------------------------------------------
    // internal streams
    // ----------------------------------------------------------------------

    // permuter output, last rides beside the data
    logic rot_valid;
    hv_t  rot_hv;
    logic rot_last;

    // key read, same cycle as rot_valid
    hv_t  key_hv;

    // ----------------------------------------------------------------------
    // stage 1, permuter and item memory side by side
    // ----------------------------------------------------------------------

    hv_permute hv_permute_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cmd_valid),
        .in_hv     (cmd.value),
        .in_shift  (cmd.shift),
        .in_last   (cmd.last),
        .out_valid (rot_valid),
        .out_hv    (rot_hv),
        .out_last  (rot_last)
    );

    item_memory item_memory_inst (
        .clk      (clk),
        .wr_valid (wr_valid),
        .wr       (wr),
        .rd_valid (cmd_valid),
        .rd_slot  (cmd.slot),
        .rd_hv    (key_hv)
    );

    // ----------------------------------------------------------------------
    // stage 2, bind and bundle
    // ----------------------------------------------------------------------

    hv_bundler hv_bundler_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rot_valid),
        .rot_hv    (rot_hv),
        .key_hv    (key_hv),
        .in_last   (rot_last),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// ==== verif/hv_encoder_chk.sv ====
`timescale 1ns/100ps

module hv_encoder_chk
    import enc_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     cmd_valid,
    input enc_cmd_t cmd,
    input logic     res_valid
);

    // failed assertions, read by the testbench summary
    int fails = 0;

    // closing item at the encoder input
    logic cmd_close;

    assign cmd_close = cmd_valid & cmd.last;

    // ----------------------------------------------------------------------
    // result strobe timing
    // ----------------------------------------------------------------------

    // output quiet after any reset edge
    a_reset_quiet: assert property (@(posedge clk) reset |=> !res_valid)
        else begin
            $error("res_valid high after a reset edge");
            fails++;
        end

    // permuter stage plus bundler stage
    a_close_to_res: assert property (@(posedge clk) disable iff (reset)
        cmd_close |-> ##2 res_valid)
        else begin
            $error("no res_valid two cycles after a closing command");
            fails++;
        end

    // every result traces back to a closing command
    a_res_has_cause: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> $past(cmd_close, 2))
        else begin
            $error("res_valid without a closing command two cycles earlier");
            fails++;
        end

endmodule

bind hv_encoder hv_encoder_chk hv_encoder_chk_inst (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .res_valid (res_valid)
);

// ==== verif/tb_hv_encoder.sv ====
`timescale 1ns/100ps

module tb_hv_encoder
    import hv_pkg::*;
    import enc_pkg::*;
();

    // cycles allowed for outstanding results to drain
    localparam int result_timeout = 40;

    logic        clk;
    logic        reset;
    logic        cmd_valid;
    enc_cmd_t    cmd;
    logic        wr_valid;
    mem_wr_t     wr;
    logic        res_valid;
    enc_result_t res;

    // reference model state
    hv_t         ref_keys [slot_count];
    int          ref_ones [hv_dim];
    int          ref_items;
    enc_result_t exp_q [$];

    // bookkeeping
    int errors;
    int tests_run;
    int tests_failed;
    int test_start_errors;

    hv_encoder hv_encoder_inst (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .wr_valid  (wr_valid),
        .wr        (wr),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    function automatic hv_t rand_hv();
        hv_t v;
        for (int w = 0; w < hv_dim / 32; w++) begin
            v[w*32 +: 32] = $urandom();
        end
        return v;
    endfunction

    // bit i takes bit i+s modulo the width
    function automatic hv_t rotate_right(hv_t v, int s);
        hv_t r;
        for (int i = 0; i < hv_dim; i++) begin
            r[i] = v[(i + s) % hv_dim];
        end
        return r;
    endfunction

    // add one item and close the record on last
    function automatic void model_item(enc_cmd_t c);
        hv_t         bound;
        enc_result_t exp;
        bound = rotate_right(c.value, int'(c.shift)) ^ ref_keys[c.slot];
        if (ref_items < max_bundle) begin
            ref_items++;
        end
        for (int i = 0; i < hv_dim; i++) begin
            if (bound[i] && ref_ones[i] < max_bundle) begin
                ref_ones[i]++;
            end
        end
        if (c.last) begin
            // strict majority with a tie giving 0
            for (int i = 0; i < hv_dim; i++) begin
                exp.hv[i] = (2 * ref_ones[i]) > ref_items;
                ref_ones[i] = 0;
            end
            exp.count = count_w'(ref_items);
            exp_q.push_back(exp);
            ref_items = 0;
        end
    endfunction

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    // one clock of stimulus entered 1 ns past an edge
    task automatic drive_cycle(logic do_wr, mem_wr_t w, logic do_cmd, enc_cmd_t c);
        wr_valid  = do_wr;
        wr        = w;
        cmd_valid = do_cmd;
        cmd       = c;
        // the read sees the table before this cycle's write
        if (do_cmd) begin
            model_item(c);
        end
        if (do_wr) begin
            ref_keys[w.slot] = w.key;
        end
        @(posedge clk);
        #1;
        wr_valid  = 1'b0;
        cmd_valid = 1'b0;
    endtask

    task automatic send_item(int slot, int shift, hv_t value, logic last);
        enc_cmd_t c;
        mem_wr_t  w;
        c.slot  = slot_w'(slot);
        c.shift = shift_w'(shift);
        c.value = value;
        c.last  = last;
        w       = '0;
        drive_cycle(1'b0, w, 1'b1, c);
    endtask

    task automatic write_key(int slot, hv_t key);
        enc_cmd_t c;
        mem_wr_t  w;
        c       = '0;
        w.slot  = slot_w'(slot);
        w.key   = key;
        drive_cycle(1'b1, w, 1'b0, c);
    endtask

    // random record of the given length with no gaps
    task automatic send_record(int len);
        for (int i = 0; i < len; i++) begin
            send_item($urandom_range(slot_count - 1), $urandom_range(hv_dim - 1),
                rand_hv(), i == len - 1);
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > result_timeout) begin
                $display("timeout: %0d results missing after %0d cycles", exp_q.size(), waited);
                $display("TEST FAIL");
                $finish;
            end
        end
        #1;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors != test_start_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    // ----------------------------------------------------------------------
    // result checks sampled mid cycle
    // ----------------------------------------------------------------------

    always @(negedge clk) begin : check_results
        enc_result_t exp;
        if (!reset && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected result strobe at %0t ns with no record open", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                assert (res.count == exp.count) else begin
                    $display("Error at %0t ns: res.count = %0d, expected %0d",
                        $time, res.count, exp.count);
                    errors++;
                end
                assert (res.hv == exp.hv) else begin
                    $display("Error at %0t ns: res.hv = %h, expected %h",
                        $time, res.hv, exp.hv);
                    errors++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------

    initial begin
        enc_cmd_t c;
        mem_wr_t  w;
        void'($urandom(26));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        wr_valid  = 1'b0;
        wr        = '0;
        errors    = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start_errors = 0;
        ref_items = 0;
        for (int i = 0; i < hv_dim; i++) begin
            ref_ones[i] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // every slot loaded before any read
        for (int s = 0; s < slot_count; s++) begin
            write_key(s, rand_hv());
        end

        // single items with edge shifts then one per shift bit
        send_item($urandom_range(slot_count - 1), 0, rand_hv(), 1'b1);
        send_item($urandom_range(slot_count - 1), hv_dim - 1, rand_hv(), 1'b1);
        for (int k = 0; k < shift_w; k++) begin
            send_item($urandom_range(slot_count - 1), 1 << k, rand_hv(), 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            send_record(1);
        end
        wait_results();
        finish_test("single item records");

        // odd lengths then a two item tie
        send_record(3);
        send_record(5);
        wait_results();
        send_record(2);
        wait_results();
        finish_test("multi item records");

        // no gap between records
        for (int r = 0; r < 6; r++) begin
            send_record($urandom_range(4, 1));
        end
        wait_results();
        finish_test("back to back records");

        // same slot write and read in one cycle
        w.slot  = 4'd5;
        w.key   = rand_hv();
        c.slot  = 4'd5;
        c.shift = shift_w'($urandom_range(hv_dim - 1));
        c.value = rand_hv();
        c.last  = 1'b1;
        drive_cycle(1'b1, w, 1'b1, c);
        send_item(5, $urandom_range(hv_dim - 1), rand_hv(), 1'b1);
        wait_results();
        finish_test("read before write");

        // zero key with all-ones value binds to all ones
        write_key(0, '0);
        for (int i = 0; i < 300; i++) begin
            send_item(0, $urandom_range(hv_dim - 1), '1, i == 299);
        end
        wait_results();
        finish_test("saturation");

        // idle tail so a stray strobe still shows
        repeat (4) @(posedge clk);
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
            tests_run, tests_failed, errors, hv_encoder_inst.hv_encoder_chk_inst.fails);
        if (errors == 0 && hv_encoder_inst.hv_encoder_chk_inst.fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/hv_pkg.sv
verilog/enc_pkg.sv
verilog/hv_permute.sv
verilog/item_memory.sv
verilog/hv_bundler.sv
verilog/hv_encoder.sv
verif/hv_encoder_chk.sv
verif/tb_hv_encoder.sv

// ==== Makefile ====
# Verilator build and run for the hypervector record encoder

SIM        := verilator
TOP        := tb_hv_encoder
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
RUN_FLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
